// File: ooo_commit.f
rtl/ooo_pkg.sv
rtl/reorder_buffer.sv
rtl/alu_unit.sv
rtl/branch_unit.sv
rtl/cdb_arbiter.sv
rtl/retire_regfile.sv
rtl/ooo_commit_top.sv
bench/ooo_commit_tb.sv

// File: bench/ooo_commit_tb.sv
// directed tests for the commit side against a queue of expected retirements
// dispatch waits on rob_full and both busy levels
// a halt holds the buffer until the next reset
`timescale 1ns/1ps

module ooo_commit_tb
    import ooo_pkg::*;
();

    localparam int test_count      = 6;
    localparam int cycles_per_test = 300;
    // slack covers the register read-back and the resets between tests
    localparam int cycle_limit     = test_count * cycles_per_test + 200;
    localparam int drain_limit     = 100;

    typedef struct packed {
        logic [xlen-1:0]        pc;
        logic [xlen-1:0]        value;
        logic                   dest_valid;
        logic [reg_idx_len-1:0] dest_reg;
        logic                   squash;
        logic [xlen-1:0]        redirect;
    } retire_exp_t;

    logic                   clock;
    logic                   reset;
    logic                   dispatch;
    dispatch_packet_t       dispatch_in;
    logic [reg_idx_len-1:0] read_reg;
    logic [rob_tag_len-1:0] alloc_tag;
    logic                   rob_full;
    logic                   alu_busy;
    logic                   branch_busy;
    retire_packet_t         retire;
    logic                   squash;
    logic [xlen-1:0]        redirect_pc;
    logic                   halt;
    logic [xlen-1:0]        read_data;

    retire_exp_t            exp_q[$];
    logic [xlen-1:0]        ref_regs [reg_count];
    logic [xlen-1:0]        next_pc;
    logic [rob_tag_len-1:0] next_tag;
    logic                   tag_clear;
    int                     errors;
    int                     checks;
    int                     squash_count;
    int                     cycles;

    ooo_commit_top u_dut (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .dispatch_in (dispatch_in),
        .read_reg    (read_reg),
        .alloc_tag   (alloc_tag),
        .rob_full    (rob_full),
        .alu_busy    (alu_busy),
        .branch_busy (branch_busy),
        .retire      (retire),
        .squash      (squash),
        .redirect_pc (redirect_pc),
        .halt        (halt),
        .read_data   (read_data)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles, the tests did not finish", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////
    // reference rules
    function automatic logic model_taken(alu_op_t op, logic [xlen-1:0] a, logic [xlen-1:0] b);
        case (op)
            op_beq:  return a == b;
            op_bne:  return a != b;
            op_blt:  return $signed(a) < $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    // branches carry their target as the result value
    function automatic logic [xlen-1:0] model_result(alu_op_t op, logic [xlen-1:0] a,
                                                     logic [xlen-1:0] b, logic [xlen-1:0] pc,
                                                     logic [xlen-1:0] offset);
        case (op)
            op_add:                 return a + b;
            op_sub:                 return a - b;
            op_and:                 return a & b;
            op_or:                  return a | b;
            op_xor:                 return a ^ b;
            op_mul:                 return a * b;
            op_beq, op_bne, op_blt: return pc + offset;
            default:                return '0;
        endcase
    endfunction

    ////////////////////
    // checking
    task automatic check_value(input string what, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // one sample per cycle between rising edges where outputs are settled
    task automatic observe();
        retire_exp_t e;
        if (reset) begin
            return;
        end
        // the tail went back to zero at the squash edge
        if (tag_clear) begin
            next_tag  = '0;
            tag_clear = 1'b0;
        end
        if (retire.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected retirement at %0t ns of the instruction at pc %h",
                         $time, retire.pc);
            end else begin
                e = exp_q.pop_front();
                check_value("retire pc", retire.pc, e.pc);
                check_value("retire value", retire.value, e.value);
                check_value("retire dest_valid", retire.dest_valid, e.dest_valid);
                if (e.dest_valid) begin
                    check_value("retire dest_reg", retire.dest_reg, e.dest_reg);
                end
                check_value("squash", squash, e.squash);
                if (e.squash) begin
                    check_value("redirect_pc", redirect_pc, e.redirect);
                end
            end
        end else if (squash === 1'b1) begin
            errors++;
            $display("squash raised at %0t ns without a retiring branch", $time);
        end
        if (squash === 1'b1) begin
            squash_count++;
            tag_clear = 1'b1;
        end
    endtask

    task automatic tick();
        @(negedge clock);
        observe();
    endtask

    task automatic apply_reset();
        reset       = 1'b1;
        dispatch    = 1'b0;
        dispatch_in = '0;
        tick();
        tick();
        reset = 1'b0;
        exp_q.delete();
        for (int r = 0; r < reg_count; r++) begin
            ref_regs[r] = '0;
        end
        next_pc   = 32'h0000_1000;
        next_tag  = '0;
        tag_clear = 1'b0;
    endtask

    ////////////////////
    // stimulus
    // retires is 0 for instructions the model expects never to leave the buffer
    task automatic dispatch_op(input alu_op_t op, input logic [xlen-1:0] a,
                               input logic [xlen-1:0] b, input logic [reg_idx_len-1:0] dest,
                               input logic pred, input logic [xlen-1:0] offset,
                               input bit retires);
        retire_exp_t e;
        logic        is_br;
        logic        taken;
        while (rob_full || alu_busy || branch_busy) begin
            tick();
        end
        // tags follow the tail in dispatch order
        check_value("alloc_tag", alloc_tag, next_tag);
        next_tag = next_tag + 1'b1;
        is_br = op inside {op_beq, op_bne, op_blt};
        taken = model_taken(op, a, b);
        dispatch_in.op         = op;
        dispatch_in.pc         = next_pc;
        dispatch_in.src_a      = a;
        dispatch_in.src_b      = b;
        dispatch_in.dest_reg   = dest;
        dispatch_in.pred_taken = pred;
        dispatch_in.offset     = offset;
        dispatch               = 1'b1;
        e.pc         = next_pc;
        e.value      = model_result(op, a, b, next_pc, offset);
        e.dest_valid = !is_br && (op != op_halt) && (dest != '0);
        e.dest_reg   = dest;
        e.squash     = is_br && (taken != pred);
        e.redirect   = taken ? next_pc + offset : next_pc + 32'd4;
        if (retires && op != op_halt) begin
            exp_q.push_back(e);
            if (e.dest_valid) begin
                ref_regs[dest] = e.value;
            end
        end
        next_pc = next_pc + 32'd4;
        tick();
        dispatch = 1'b0;
    endtask

    // extra cycle lets the last write land and a pending squash clear
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_limit) begin
            tick();
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("retirement stalled at %0t ns with %0d instructions outstanding",
                     $time, exp_q.size());
            exp_q.delete();
        end
        tick();
    endtask

    task automatic check_regs(input int first, input int last);
        for (int r = first; r <= last; r++) begin
            read_reg = reg_idx_len'(r);
            tick();
            check_value($sformatf("register x%0d", r), read_data, ref_regs[r]);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s done, %0d errors", name, errors - errors_before);
    endtask

    ////////////////////
    // tests
    task automatic test_random_alu();
        alu_op_t                op;
        logic [reg_idx_len-1:0] dest;
        int                     first_errors;
        first_errors = errors;
        apply_reset();
        for (int i = 0; i < 16; i++) begin
            op   = alu_op_t'($urandom_range(0, 5));
            // a few writes aimed at x0
            dest = (i % 5 == 2) ? '0 : reg_idx_len'($urandom_range(1, 12));
            dispatch_op(op, $urandom, $urandom, dest, 1'b0, '0, 1'b1);
        end
        drain();
        check_regs(0, reg_count - 1);
        report_test("random_alu", first_errors);
    endtask

    task automatic test_mul_then_adds();
        int first_errors;
        first_errors = errors;
        apply_reset();
        dispatch_op(op_mul, $urandom, $urandom, 5'd1, 1'b0, '0, 1'b1);
        dispatch_op(op_add, $urandom, $urandom, 5'd2, 1'b0, '0, 1'b1);
        dispatch_op(op_add, $urandom, $urandom, 5'd3, 1'b0, '0, 1'b1);
        dispatch_op(op_sub, $urandom, $urandom, 5'd4, 1'b0, '0, 1'b1);
        drain();
        check_regs(1, 4);
        report_test("mul_then_adds", first_errors);
    endtask

    task automatic test_branch_predicted();
        int first_errors;
        int squash_before;
        first_errors  = errors;
        squash_before = squash_count;
        apply_reset();
        dispatch_op(op_add, $urandom, $urandom, 5'd1, 1'b0, '0, 1'b1);
        dispatch_op(op_beq, 32'd7, 32'd7, '0, 1'b1, 32'h40, 1'b1);
        dispatch_op(op_bne, 32'd9, 32'd9, '0, 1'b0, 32'h80, 1'b1);
        dispatch_op(op_add, $urandom, $urandom, 5'd2, 1'b0, '0, 1'b1);
        dispatch_op(op_xor, $urandom, $urandom, 5'd3, 1'b0, '0, 1'b1);
        drain();
        check_value("squash count", squash_count - squash_before, 0);
        check_regs(1, 3);
        report_test("branch_predicted", first_errors);
    endtask

    task automatic test_branch_mispredict();
        int first_errors;
        int squash_before;
        first_errors  = errors;
        squash_before = squash_count;
        apply_reset();
        // taken blt predicted not taken and held back by two older multiplies
        dispatch_op(op_mul, $urandom, $urandom, 5'd1, 1'b0, '0, 1'b1);
        dispatch_op(op_mul, $urandom, $urandom, 5'd2, 1'b0, '0, 1'b1);
        dispatch_op(op_blt, 32'hffff_fffb, 32'd3, '0, 1'b0, 32'h100, 1'b1);
        dispatch_op(op_add, $urandom, $urandom, 5'd3, 1'b0, '0, 1'b0);
        dispatch_op(op_xor, $urandom, $urandom, 5'd4, 1'b0, '0, 1'b0);
        drain();
        // not-taken beq predicted taken
        dispatch_op(op_add, $urandom, $urandom, 5'd5, 1'b0, '0, 1'b1);
        dispatch_op(op_beq, 32'd1, 32'd2, '0, 1'b1, 32'h200, 1'b1);
        dispatch_op(op_sub, $urandom, $urandom, 5'd6, 1'b0, '0, 1'b0);
        dispatch_op(op_and, $urandom, $urandom, 5'd7, 1'b0, '0, 1'b0);
        drain();
        dispatch_op(op_or, $urandom, $urandom, 5'd8, 1'b0, '0, 1'b1);
        drain();
        check_value("squash count", squash_count - squash_before, 2);
        check_regs(1, 8);
        report_test("branch_mispredict", first_errors);
    endtask

    task automatic test_rob_full();
        int first_errors;
        first_errors = errors;
        apply_reset();
        // a halt at the head keeps every multiply behind it in the buffer
        dispatch_op(op_halt, '0, '0, '0, 1'b0, '0, 1'b0);
        for (int i = 0; i < rob_size - 1; i++) begin
            dispatch_op(op_mul, $urandom, $urandom, reg_idx_len'(i + 1), 1'b0, '0, 1'b0);
        end
        check_value("rob_full", rob_full, 1);
        repeat (6) tick();
        check_value("rob_full held", rob_full, 1);
        check_value("halt", halt, 1);
        apply_reset();
        check_value("rob_full after reset", rob_full, 0);
        for (int i = 0; i < rob_size; i++) begin
            dispatch_op(op_mul, $urandom, $urandom, reg_idx_len'(i + 1), 1'b0, '0, 1'b1);
        end
        drain();
        check_regs(1, rob_size);
        report_test("rob_full", first_errors);
    endtask

    task automatic test_halt();
        int first_errors;
        first_errors = errors;
        apply_reset();
        dispatch_op(op_add, $urandom, $urandom, 5'd5, 1'b0, '0, 1'b1);
        dispatch_op(op_mul, $urandom, $urandom, 5'd6, 1'b0, '0, 1'b1);
        dispatch_op(op_sub, $urandom, $urandom, 5'd7, 1'b0, '0, 1'b1);
        dispatch_op(op_halt, '0, '0, '0, 1'b0, '0, 1'b0);
        dispatch_op(op_add, $urandom, $urandom, 5'd8, 1'b0, '0, 1'b0);
        dispatch_op(op_or, $urandom, $urandom, 5'd9, 1'b0, '0, 1'b0);
        drain();
        for (int i = 0; i < 20 && halt !== 1'b1; i++) begin
            tick();
        end
        check_value("halt", halt, 1);
        repeat (10) tick();
        check_value("halt held", halt, 1);
        check_value("retire valid", retire.valid, 0);
        check_regs(5, 9);
        report_test("halt", first_errors);
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        dispatch     = 1'b0;
        dispatch_in  = '0;
        read_reg     = '0;
        errors       = 0;
        checks       = 0;
        squash_count = 0;
        cycles       = 0;
        next_pc      = 32'h0000_1000;
        next_tag     = '0;
        tag_clear    = 1'b0;
        void'($urandom(32'hfbed_90f2));
        test_random_alu();
        test_mul_then_adds();
        test_branch_predicted();
        test_branch_mispredict();
        test_rob_full();
        test_halt();
        $display("%0d tests, %0d checks, %0d errors, %0d squashes, %0d cycles",
                 test_count, checks, errors, squash_count, cycles);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: rtl/ooo_commit_top.sv
// commit side: reorder buffer, two units on one CDB, retire register file
// hold dispatch while rob_full, alu_busy or branch_busy is high
`timescale 1ns/1ps

module ooo_commit_top
    import ooo_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   dispatch,
    input  dispatch_packet_t       dispatch_in,
    input  logic [reg_idx_len-1:0] read_reg,
    output logic [rob_tag_len-1:0] alloc_tag,
    output logic                   rob_full,
    output logic                   alu_busy,
    output logic                   branch_busy,
    output retire_packet_t         retire,
    output logic                   squash,
    output logic [xlen-1:0]        redirect_pc,
    output logic                   halt,
    output logic [xlen-1:0]        read_data
);

    issue_packet_t issue;
    cdb_packet_t   cdb;
    cdb_packet_t   alu_result;
    cdb_packet_t   branch_result;
    logic          alu_request;
    logic          alu_grant;
    logic          branch_request;
    logic          branch_grant;

    // the tail index tags the instruction
    assign issue.inst = dispatch_in;
    assign issue.tag  = alloc_tag;

    reorder_buffer u_rob (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .dispatch_in (dispatch_in),
        .cdb         (cdb),
        .alloc_tag   (alloc_tag),
        .rob_full    (rob_full),
        .retire      (retire),
        .squash      (squash),
        .redirect_pc (redirect_pc),
        .halt        (halt)
    );

    alu_unit u_alu (
        .clock    (clock),
        .reset    (reset),
        .dispatch (dispatch),
        .issue    (issue),
        .grant    (alu_grant),
        .squash   (squash),
        .request  (alu_request),
        .result   (alu_result),
        .busy     (alu_busy)
    );

    branch_unit u_branch (
        .clock    (clock),
        .reset    (reset),
        .dispatch (dispatch),
        .issue    (issue),
        .grant    (branch_grant),
        .squash   (squash),
        .request  (branch_request),
        .result   (branch_result),
        .busy     (branch_busy)
    );

    cdb_arbiter u_arbiter (
        .clock          (clock),
        .reset          (reset),
        .alu_request    (alu_request),
        .alu_result     (alu_result),
        .branch_request (branch_request),
        .branch_result  (branch_result),
        .alu_grant      (alu_grant),
        .branch_grant   (branch_grant),
        .cdb            (cdb)
    );

    retire_regfile u_regfile (
        .clock     (clock),
        .reset     (reset),
        .retire    (retire),
        .read_reg  (read_reg),
        .read_data (read_data)
    );

endmodule

// File: rtl/retire_regfile.sv
// architectural registers, written only at retire
// x0 reads zero, the read port is combinational
`timescale 1ns/1ps

module retire_regfile
    import ooo_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  retire_packet_t         retire,
    input  logic [reg_idx_len-1:0] read_reg,
    output logic [xlen-1:0]        read_data
);

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.dest_valid && retire.dest_reg != '0) begin
            regs[retire.dest_reg] <= retire.value;
        end
    end

    assign read_data = regs[read_reg];

endmodule

// File: rtl/cdb_arbiter.sv
// round-robin between the ALU and the branch unit with the alu first after reset
// the bus is all zero when nobody is granted
`timescale 1ns/1ps

module cdb_arbiter
    import ooo_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        alu_request,
    input  cdb_packet_t alu_result,
    input  logic        branch_request,
    input  cdb_packet_t branch_result,
    output logic        alu_grant,
    output logic        branch_grant,
    output cdb_packet_t cdb
);

    // set when the branch unit won last
    logic last_branch;

    assign alu_grant    = alu_request && (!branch_request || last_branch);
    assign branch_grant = branch_request && (!alu_request || !last_branch);

    always_comb begin
        if (alu_grant) begin
            cdb = alu_result;
        end else if (branch_grant) begin
            cdb = branch_result;
        end else begin
            cdb = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            last_branch <= 1'b1;
        end else if (alu_grant) begin
            last_branch <= 1'b0;
        end else if (branch_grant) begin
            last_branch <= 1'b1;
        end
    end

    ////////////////////
    // checks
    a_one_grant: assert property (
        @(posedge clock) disable iff (reset)
        !(alu_grant && branch_grant)
    );

    // under contention the loser wins the next cycle
    a_alternate: assert property (
        @(posedge clock) disable iff (reset)
        (alu_grant && branch_request) |=>
            (!(alu_request && branch_request) || branch_grant)
    );

endmodule

// File: rtl/branch_unit.sv
// resolves beq, bne and blt; blt compares signed
// results wait in a 2-entry holding buffer, dispatch must wait while busy
`timescale 1ns/1ps

module branch_unit
    import ooo_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          dispatch,
    input  issue_packet_t issue,
    input  logic          grant,
    input  logic          squash,
    output logic          request,
    output cdb_packet_t   result,
    output logic          busy
);

    cdb_packet_t [1:0] hold;
    cdb_packet_t [1:0] hold_next;
    logic [1:0]        hold_count;
    logic [1:0]        count_next;
    cdb_packet_t       new_pkt;
    logic              push;
    logic              taken;

    assign push = dispatch && is_branch_op(issue.inst.op);

    always_comb begin
        case (issue.inst.op)
            op_beq:  taken = (issue.inst.src_a == issue.inst.src_b);
            op_bne:  taken = (issue.inst.src_a != issue.inst.src_b);
            default: taken = ($signed(issue.inst.src_a) < $signed(issue.inst.src_b));
        endcase
        new_pkt.valid = 1'b1;
        new_pkt.tag   = issue.tag;
        // target is always sent, the buffer picks pc + 4 itself
        new_pkt.value = issue.inst.pc + issue.inst.offset;
        new_pkt.taken = taken;
    end

    ////////////////////
    // holding buffer
    always_comb begin
        hold_next  = hold;
        count_next = hold_count;
        if (grant && hold_count != 2'd0) begin
            hold_next[0] = hold[1];
            count_next   = count_next - 2'd1;
        end
        if (push) begin
            hold_next[count_next[0]] = new_pkt;
            count_next               = count_next + 2'd1;
        end
    end

    assign request = (hold_count != 2'd0);
    assign busy    = (hold_count == 2'd2);

    always_comb begin
        result       = hold[0];
        result.valid = request;
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            hold_count <= '0;
        end else begin
            hold_count <= count_next;
        end
    end

    always_ff @(posedge clock) begin
        hold <= hold_next;
    end

endmodule

// File: rtl/alu_unit.sv
// add, sub and logic in one cycle, multiply over mul_stages cycles
// results wait in a 2-entry holding buffer, dispatch must wait while busy
`timescale 1ns/1ps

module alu_unit
    import ooo_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          dispatch,
    input  issue_packet_t issue,
    input  logic          grant,
    input  logic          squash,
    output logic          request,
    output cdb_packet_t   result,
    output logic          busy
);

    cdb_packet_t [1:0]            hold;
    cdb_packet_t [1:0]            hold_next;
    logic [1:0]                   hold_count;
    logic [1:0]                   count_next;
    // writing the holding buffer is the last multiply stage
    cdb_packet_t [mul_stages-2:0] mul_pipe;
    cdb_packet_t                  mul_out;
    cdb_packet_t                  single_pkt;
    logic [xlen-1:0]              single_value;
    logic                         single_push;
    logic                         mul_issue;
    logic                         mul_push;
    logic                         mul_stall;

    assign single_push = dispatch && is_alu_op(issue.inst.op) && (issue.inst.op != op_mul);
    assign mul_issue   = dispatch && (issue.inst.op == op_mul);
    assign mul_out     = mul_pipe[mul_stages-2];

    always_comb begin
        case (issue.inst.op)
            op_sub:  single_value = issue.inst.src_a - issue.inst.src_b;
            op_and:  single_value = issue.inst.src_a & issue.inst.src_b;
            op_or:   single_value = issue.inst.src_a | issue.inst.src_b;
            op_xor:  single_value = issue.inst.src_a ^ issue.inst.src_b;
            default: single_value = issue.inst.src_a + issue.inst.src_b;
        endcase
        single_pkt.valid = 1'b1;
        single_pkt.tag   = issue.tag;
        single_pkt.value = single_value;
        single_pkt.taken = 1'b0;
    end

    ////////////////////
    // holding buffer, pop first, then single, then multiply
    always_comb begin
        hold_next  = hold;
        count_next = hold_count;
        mul_push   = 1'b0;
        if (grant && hold_count != 2'd0) begin
            hold_next[0] = hold[1];
            count_next   = count_next - 2'd1;
        end
        if (single_push) begin
            hold_next[count_next[0]] = single_pkt;
            count_next               = count_next + 2'd1;
        end
        // multiply gives way when no slot is left
        if (mul_out.valid && count_next != 2'd2) begin
            hold_next[count_next[0]] = mul_out;
            count_next               = count_next + 2'd1;
            mul_push                 = 1'b1;
        end
    end

    assign mul_stall = mul_out.valid && !mul_push;
    assign request   = (hold_count != 2'd0);
    assign busy      = (hold_count == 2'd2);

    always_comb begin
        result       = hold[0];
        result.valid = request;
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            hold_count <= '0;
            for (int i = 0; i < mul_stages - 1; i++) begin
                mul_pipe[i].valid <= 1'b0;
            end
        end else begin
            hold_count <= count_next;
            // the whole pipe holds while its last stage waits
            if (!mul_stall) begin
                mul_pipe[0].valid <= mul_issue;
                mul_pipe[0].tag   <= issue.tag;
                mul_pipe[0].value <= issue.inst.src_a * issue.inst.src_b;
                mul_pipe[0].taken <= 1'b0;
                for (int i = 1; i < mul_stages - 1; i++) begin
                    mul_pipe[i] <= mul_pipe[i-1];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        hold <= hold_next;
    end

    // busy holds dispatch off, so a single-cycle result always finds a slot
    a_hold_no_overflow: assert property (
        @(posedge clock) disable iff (reset)
        single_push |-> (hold_count != 2'd2 || grant)
    );

endmodule

// File: rtl/reorder_buffer.sv
// in-order retire of one entry per cycle, squash on a mispredicted branch
// no dispatch while rob_full; a halt at the head holds the buffer until reset
`timescale 1ns/1ps

module reorder_buffer
    import ooo_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   dispatch,
    input  dispatch_packet_t       dispatch_in,
    input  cdb_packet_t            cdb,
    output logic [rob_tag_len-1:0] alloc_tag,
    output logic                   rob_full,
    output retire_packet_t         retire,
    output logic                   squash,
    output logic [xlen-1:0]        redirect_pc,
    output logic                   halt
);

    rob_entry_t [rob_size-1:0] entries;
    logic [rob_tag_len-1:0]    head;
    logic [rob_tag_len-1:0]    tail;
    logic [rob_tag_len:0]      count;
    rob_entry_t                head_entry;
    rob_entry_t                new_entry;
    logic                      retire_fire;

    ////////////////////
    // head decode
    assign head_entry  = entries[head];
    assign alloc_tag   = tail;
    assign rob_full    = (count == (rob_tag_len + 1)'(rob_size));

    // halt is born ready but never leaves the head
    assign retire_fire = head_entry.valid && head_entry.ready && !head_entry.halt;
    assign halt        = head_entry.valid && head_entry.halt;
    assign squash      = retire_fire && head_entry.is_branch && head_entry.mis_pred;

    // predicted taken means the real path is the fall-through
    assign redirect_pc = head_entry.pred_taken ? head_entry.pc + xlen'(4)
                                               : head_entry.value;

    always_comb begin
        retire.valid      = retire_fire;
        retire.dest_valid = retire_fire && !head_entry.is_branch
                            && (head_entry.dest_reg != '0);
        retire.dest_reg   = head_entry.dest_reg;
        retire.value      = head_entry.value;
        retire.pc         = head_entry.pc;
    end

    ////////////////////
    // new entry at the tail
    always_comb begin
        new_entry            = '0;
        new_entry.valid      = 1'b1;
        new_entry.ready      = (dispatch_in.op == op_halt);
        new_entry.pc         = dispatch_in.pc;
        new_entry.dest_reg   = dispatch_in.dest_reg;
        new_entry.is_branch  = is_branch_op(dispatch_in.op);
        new_entry.pred_taken = dispatch_in.pred_taken;
        new_entry.halt       = (dispatch_in.op == op_halt);
    end

    ////////////////////
    // allocate, complete, retire
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (dispatch) begin
                entries[tail] <= new_entry;
                tail          <= tail + 1'b1;
            end

            // completion from the bus
            if (cdb.valid && entries[cdb.tag].valid) begin
                entries[cdb.tag].ready    <= 1'b1;
                entries[cdb.tag].value    <= cdb.value;
                entries[cdb.tag].mis_pred <= entries[cdb.tag].is_branch
                                             && (cdb.taken != entries[cdb.tag].pred_taken);
            end

            if (retire_fire) begin
                entries[head].valid <= 1'b0;
                head                <= head + 1'b1;
            end

            if (dispatch && !retire_fire) begin
                count <= count + 1'b1;
            end else if (!dispatch && retire_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    ////////////////////
    // checks
    // the dispatch side has no stall path into the buffer
    a_no_dispatch_when_full: assert property (
        @(posedge clock) disable iff (reset)
        dispatch |-> !rob_full
    );

    // units are flushed with the buffer, so every broadcast finds a live entry
    a_cdb_hits_live_entry: assert property (
        @(posedge clock) disable iff (reset)
        cdb.valid |-> entries[cdb.tag].valid
    );

endmodule

// File: rtl/ooo_pkg.sv
// shared sizes, opcodes and packets of the commit side
// rob_size must stay a power of two, head and tail wrap by overflow
package ooo_pkg;

    ////////////////////
    // sizes
    localparam int xlen        = 32;
    localparam int rob_size    = 8;
    localparam int rob_tag_len = 3;
    localparam int reg_count   = 32;
    localparam int reg_idx_len = 5;
    localparam int mul_stages  = 3;

    ////////////////////
    // opcodes
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        op_mul  = 4'h5,
        op_beq  = 4'h6,
        op_bne  = 4'h7,
        op_blt  = 4'h8,
        op_halt = 4'h9
    } alu_op_t;

    // opcode classes, one unit per class
    function automatic logic is_alu_op(alu_op_t op);
        return op inside {op_add, op_sub, op_and, op_or, op_xor, op_mul};
    endfunction

    function automatic logic is_branch_op(alu_op_t op);
        return op inside {op_beq, op_bne, op_blt};
    endfunction

    ////////////////////
    // packets
    typedef struct packed {
        alu_op_t                op;
        logic [xlen-1:0]        pc;
        logic [xlen-1:0]        src_a;
        logic [xlen-1:0]        src_b;
        logic [reg_idx_len-1:0] dest_reg;
        logic                   pred_taken;
        logic [xlen-1:0]        offset;      // branch target offset
    } dispatch_packet_t;

    typedef struct packed {
        dispatch_packet_t       inst;
        logic [rob_tag_len-1:0] tag;
    } issue_packet_t;

    typedef struct packed {
        logic                   valid;
        logic [rob_tag_len-1:0] tag;
        logic [xlen-1:0]        value;       // target pc for a branch
        logic                   taken;
    } cdb_packet_t;

    typedef struct packed {
        logic                   valid;
        logic                   dest_valid;
        logic [reg_idx_len-1:0] dest_reg;
        logic [xlen-1:0]        value;
        logic [xlen-1:0]        pc;
    } retire_packet_t;

    typedef struct packed {
        logic                   valid;
        logic                   ready;
        logic [xlen-1:0]        pc;
        logic [reg_idx_len-1:0] dest_reg;
        logic [xlen-1:0]        value;
        logic                   is_branch;
        logic                   pred_taken;
        logic                   mis_pred;
        logic                   halt;
    } rob_entry_t;

endpackage
